//--- build.f
source/chol_pkg.sv
source/chol_sequencer.sv
source/tri_matrix_store.sv
source/fix_sqrt.sv
source/fix_div.sv
source/chol_arith.sv
source/cholesky_top.sv
test/tb_cholesky.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_cholesky -o sim_cholesky
out=$(./obj_dir/sim_cholesky)
echo "$out"
if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- source/chol_arith.sv
`timescale 1ns/1ns
`default_nettype none

module chol_arith (
    input  logic           clk,
    input  logic           rst,
    input  logic           op_start,
    input  chol_pkg::op_t  op,
    input  chol_pkg::fix_t a_elem,
    input  chol_pkg::fix_t lx_elem,
    input  chol_pkg::fix_t ly_elem,
    output logic           op_done,
    output chol_pkg::fix_t result
);
    import chol_pkg::*;

    acc_t acc;
    fix_t corrected;
    logic mac_done;
    logic sqrt_start;
    logic sqrt_done;
    fix_t root;
    logic div_start;
    logic div_done;
    fix_t quotient;

    // A minus the Q16.16 part of the accumulated products
    assign corrected = a_elem - $signed(acc[FRAC_BITS +: 32]);

    assign sqrt_start = op_start && (op == OP_SQRT);
    assign div_start  = op_start && (op == OP_DIV);

    // ------------------------------------------------------------
    // Accumulator
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            acc      <= '0;
            mac_done <= 1'b0;
        end else begin
            mac_done <= op_start && (op == OP_MAC);
            if (op_start) begin
                if (op == OP_MAC) begin
                    acc <= acc + acc_t'(lx_elem) * acc_t'(ly_elem);   // Full 64-bit product
                end else begin
                    acc <= '0;                 // Units already hold the corrected value
                end
            end
        end
    end

    fix_sqrt u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .start    (sqrt_start),
        .radicand (corrected),
        .done     (sqrt_done),
        .root     (root)
    );

    // Divisor is L(j,j) from the store
    fix_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (corrected),
        .divisor  (ly_elem),
        .done     (div_done),
        .quotient (quotient)
    );

    assign op_done = mac_done || sqrt_done || div_done;
    assign result  = sqrt_done ? root : quotient;

    a_div_nonzero: assert property (
        @(posedge clk) disable iff (rst) div_start |-> (ly_elem != '0)
    );

endmodule

`default_nettype wire

//--- source/chol_pkg.sv
`default_nettype none

package chol_pkg;

    typedef logic signed [31:0] fix_t;  // Q16.16
    typedef logic signed [63:0] acc_t;  // Sum of Q32.32 products
    typedef logic [7:0]         idx_t;  // Packed element or row index

    localparam int DEFAULT_N = 4;
    localparam int FRAC_BITS = 16;

    typedef enum logic [1:0] {
        OP_MAC,   // acc += lx * ly
        OP_SQRT,  // sqrt(a - acc), then clear acc
        OP_DIV    // (a - acc) / ly, then clear acc
    } op_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_ISSUE,  // First operation of a run
        S_WAIT,
        S_NEXT,   // Follow-on operation after a done pulse
        S_DONE
    } seq_state_t;

    // Number of elements in a lower triangle of size n
    function automatic int tri_elems(input int n);
        return n * (n + 1) / 2;
    endfunction

    // Row-major packed position of (row, col), col <= row
    function automatic idx_t tri_index(input idx_t row, input idx_t col);
        int pos;
        pos = int'(row) * (int'(row) + 1) / 2 + int'(col);
        return idx_t'(pos);
    endfunction

endpackage

`default_nettype wire

//--- source/chol_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module chol_sequencer #(
    parameter int N
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           a_valid,
    input  logic           op_done,
    output logic           load,
    output logic           op_start,
    output chol_pkg::op_t  op,
    output chol_pkg::idx_t a_idx,
    output chol_pkg::idx_t lx_idx,
    output chol_pkg::idx_t ly_idx,
    output chol_pkg::idx_t wr_idx,
    output logic           wr_en,
    output logic           l_valid
);
    import chol_pkg::*;

    localparam idx_t LAST = idx_t'(N - 1);

    seq_state_t state;
    idx_t       col_j;     // Column being solved
    idx_t       row_i;     // Row in column, col_j and below
    idx_t       k;         // Product term, k == col_j is the final op
    logic       final_op;
    logic       last_op;
    logic       pending;   // Operation issued, done not yet seen

    assign final_op = (k == col_j);
    assign last_op  = final_op && (row_i == LAST) && (col_j == LAST);

    always_comb begin
        if (!final_op) begin
            op = OP_MAC;
        end else if (row_i == col_j) begin
            op = OP_SQRT;
        end else begin
            op = OP_DIV;
        end
    end

    // ------------------------------------------------------------
    // Element addressing
    // ------------------------------------------------------------
    assign a_idx  = tri_index(row_i, col_j);
    assign wr_idx = a_idx;                     // L(i,j) replaces A(i,j) position
    assign lx_idx = tri_index(row_i, k);       // L(i,k)
    assign ly_idx = tri_index(col_j, k);       // L(j,k), or L(j,j) on the final op

    assign load     = (state == S_IDLE) && a_valid;
    assign op_start = (state == S_ISSUE) || (state == S_NEXT);
    assign wr_en    = (state == S_WAIT) && op_done && final_op;
    assign l_valid  = (state == S_DONE);

    // ------------------------------------------------------------
    // Column, row and term stepping
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            col_j <= '0;
            row_i <= '0;
            k     <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (a_valid) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    col_j <= '0;
                    row_i <= '0;
                    k     <= '0;
                    state <= S_ISSUE;
                end
                S_ISSUE, S_NEXT: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (op_done) begin
                        if (last_op) begin
                            state <= S_DONE;
                        end else begin
                            state <= S_NEXT;
                            if (!final_op) begin
                                k <= k + idx_t'(1);
                            end else begin
                                k <= '0;
                                if (row_i != LAST) begin
                                    row_i <= row_i + idx_t'(1);
                                end else begin
                                    col_j <= col_j + idx_t'(1);   // Next column starts on diagonal
                                    row_i <= col_j + idx_t'(1);
                                end
                            end
                        end
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (op_start) begin
            pending <= 1'b1;
        end else if (op_done) begin
            pending <= 1'b0;
        end
    end

    // A done pulse belongs to the one operation in flight
    a_single_op: assert property (
        @(posedge clk) disable iff (rst) op_done |-> pending
    );

endmodule

`default_nettype wire

//--- source/cholesky_top.sv
`timescale 1ns/1ns
`default_nettype none

module cholesky_top #(
    parameter int N = chol_pkg::DEFAULT_N
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  chol_pkg::fix_t [chol_pkg::tri_elems(N)-1:0]   a,
    input  logic                                          a_valid,
    output chol_pkg::fix_t [chol_pkg::tri_elems(N)-1:0]   l,
    output logic                                          l_valid
);
    import chol_pkg::*;

    logic load;
    logic op_start;
    logic op_done;
    logic wr_en;
    op_t  op;
    idx_t a_idx;
    idx_t lx_idx;
    idx_t ly_idx;
    idx_t wr_idx;
    fix_t a_elem;
    fix_t lx_elem;
    fix_t ly_elem;
    fix_t result;

    chol_sequencer #(
        .N (N)
    ) u_seq (
        .clk      (clk),
        .rst      (rst),
        .a_valid  (a_valid),
        .op_done  (op_done),
        .load     (load),
        .op_start (op_start),
        .op       (op),
        .a_idx    (a_idx),
        .lx_idx   (lx_idx),
        .ly_idx   (ly_idx),
        .wr_idx   (wr_idx),
        .wr_en    (wr_en),
        .l_valid  (l_valid)
    );

    tri_matrix_store #(
        .N (N)
    ) u_store (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .a       (a),
        .a_idx   (a_idx),
        .lx_idx  (lx_idx),
        .ly_idx  (ly_idx),
        .wr_idx  (wr_idx),
        .wr_en   (wr_en),
        .result  (result),
        .a_elem  (a_elem),
        .lx_elem (lx_elem),
        .ly_elem (ly_elem),
        .l       (l)
    );

    chol_arith u_arith (
        .clk      (clk),
        .rst      (rst),
        .op_start (op_start),
        .op       (op),
        .a_elem   (a_elem),
        .lx_elem  (lx_elem),
        .ly_elem  (ly_elem),
        .op_done  (op_done),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- source/fix_div.sv
`timescale 1ns/1ns
`default_nettype none

module fix_div (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::fix_t dividend,
    input  chol_pkg::fix_t divisor,
    output logic           done,
    output chol_pkg::fix_t quotient
);
    import chol_pkg::*;

    localparam int NUM_W = 32 + FRAC_BITS;   // Dividend scaled by 2^16

    logic [NUM_W-1:0]          num;      // Dividend bits out, quotient bits in
    logic [31:0]               rem;
    logic [31:0]               dmag;
    logic [32:0]               rem_sh;
    logic [32:0]               rem_diff;
    logic [31:0]               dd_mag;
    logic [31:0]               dv_mag;
    logic                      neg;
    logic                      dzero;
    logic                      busy;
    logic                      fixup;    // Sign and saturation cycle
    logic [$clog2(NUM_W)-1:0]  cnt;

    assign dd_mag   = dividend[31] ? -dividend : dividend;
    assign dv_mag   = divisor[31] ? -divisor : divisor;
    assign rem_sh   = {rem, num[NUM_W-1]};
    assign rem_diff = rem_sh - {1'b0, dmag};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            fixup <= 1'b0;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == ($clog2(NUM_W))'(NUM_W - 1)) begin
                    busy  <= 1'b0;
                    fixup <= 1'b1;
                end
            end else if (fixup) begin
                fixup <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Restoring division on magnitudes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            num   <= {dd_mag, {FRAC_BITS{1'b0}}};
            rem   <= '0;
            dmag  <= dv_mag;
            neg   <= dividend[31] ^ divisor[31];
            dzero <= (divisor == '0);
        end else if (busy) begin
            if (rem_sh >= {1'b0, dmag}) begin
                rem <= rem_diff[31:0];
                num <= {num[NUM_W-2:0], 1'b1};
            end else begin
                rem <= rem_sh[31:0];
                num <= {num[NUM_W-2:0], 1'b0};
            end
        end else if (fixup) begin
            if (dzero) begin
                quotient <= 32'h7fff_ffff;
            end else if (neg) begin
                quotient <= -num[31:0];              // Truncates toward zero
            end else begin
                quotient <= num[31:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fix_sqrt.sv
`timescale 1ns/1ns
`default_nettype none

module fix_sqrt (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::fix_t radicand,
    output logic           done,
    output chol_pkg::fix_t root
);
    import chol_pkg::*;

    localparam int OP_W   = 32 + FRAC_BITS;   // Radicand scaled by 2^16
    localparam int ROOT_W = OP_W / 2;
    localparam int REM_W  = ROOT_W + 3;

    logic [OP_W-1:0]              op_q;
    logic [ROOT_W-1:0]            q;
    logic [REM_W-1:0]             rem;
    logic [REM_W-1:0]             rem_sh;
    logic [REM_W-1:0]             trial;
    logic [$clog2(ROOT_W)-1:0]    cnt;
    logic                         busy;

    // Bring down the next two operand bits, try 4q+1
    assign rem_sh = {rem[REM_W-3:0], op_q[OP_W-1 -: 2]};
    assign trial  = {1'b0, q, 2'b01};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == ($clog2(ROOT_W))'(ROOT_W - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // One root bit per cycle
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= radicand[31] ? '0 : {radicand, {FRAC_BITS{1'b0}}};   // Negative gives 0
            rem  <= '0;
            q    <= '0;
        end else if (busy) begin
            op_q <= op_q << 2;
            if (rem_sh >= trial) begin
                rem <= rem_sh - trial;
                q   <= {q[ROOT_W-2:0], 1'b1};
            end else begin
                rem <= rem_sh;
                q   <= {q[ROOT_W-2:0], 1'b0};
            end
        end
    end

    assign root = {{(32 - ROOT_W){1'b0}}, q};

endmodule

`default_nettype wire

//--- source/tri_matrix_store.sv
`timescale 1ns/1ns
`default_nettype none

module tri_matrix_store #(
    parameter int N
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          load,
    input  chol_pkg::fix_t [chol_pkg::tri_elems(N)-1:0]   a,
    input  chol_pkg::idx_t                                a_idx,
    input  chol_pkg::idx_t                                lx_idx,
    input  chol_pkg::idx_t                                ly_idx,
    input  chol_pkg::idx_t                                wr_idx,
    input  logic                                          wr_en,
    input  chol_pkg::fix_t                                result,
    output chol_pkg::fix_t                                a_elem,
    output chol_pkg::fix_t                                lx_elem,
    output chol_pkg::fix_t                                ly_elem,
    output chol_pkg::fix_t [chol_pkg::tri_elems(N)-1:0]   l
);
    import chol_pkg::*;

    localparam int TRI = tri_elems(N);

    fix_t [TRI-1:0] a_q;   // Loaded A triangle
    fix_t [TRI-1:0] l_q;   // L triangle as it fills in

    always_ff @(posedge clk) begin
        if (load) begin
            a_q <= a;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || load) begin
            l_q <= '0;                 // Fresh factor for every matrix
        end else if (wr_en) begin
            l_q[wr_idx] <= result;
        end
    end

    // Combinational read ports
    assign a_elem  = a_q[a_idx];
    assign lx_elem = l_q[lx_idx];
    assign ly_elem = l_q[ly_idx];

    assign l = l_q;

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> (int'(wr_idx) < TRI)
    );

endmodule

`default_nettype wire

//--- test/tb_cholesky.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cholesky;
    import chol_pkg::*;

    localparam int N           = DEFAULT_N;
    localparam int TRI         = tri_elems(N);
    localparam int NUM_RANDOM  = 20;
    localparam int MATRICES    = NUM_RANDOM + 5;              // Directed runs plus aborted one
    localparam int TIMEOUT_CYC = MATRICES * N * N * 60 + 5000;

    typedef fix_t [TRI-1:0] tri_t;

    logic        clk;
    logic        rst;
    tri_t        a;
    logic        a_valid;
    tri_t        l;
    logic        l_valid;

    tri_t        expected_l;   // Factor the compare process checks against
    int          pulses;       // l_valid pulses seen
    int          exp_pulses;
    int          err_count;
    int          cycles;
    logic [31:0] lfsr_q;

    cholesky_top DUT (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // Stimulus and reference helpers
    // ------------------------------------------------------------
    function automatic int tri_pos(input int row, input int col);
        return row * (row + 1) / 2 + col;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Floor of the square root, one result bit at a time from the top
    function automatic fix_t int_sqrt(input longint x);
        longint r;
        longint t;
        r = 0;
        for (int b = 23; b >= 0; b--) begin
            t = r | (longint'(1) <<< b);
            if (t * t <= x) begin
                r = t;
            end
        end
        return fix_t'(r);
    endfunction

    function automatic tri_t cholesky_ref(input tri_t am);
        tri_t   lm;
        longint acc;
        longint num;
        fix_t   c;
        fix_t   d;
        lm = '0;
        for (int j = 0; j < N; j++) begin
            for (int i = j; i < N; i++) begin
                acc = 0;
                for (int k = 0; k < j; k++) begin
                    acc = acc + longint'(lm[tri_pos(i, k)]) * longint'(lm[tri_pos(j, k)]);
                end
                c = am[tri_pos(i, j)] - fix_t'(acc >>> 16);   // Bits 47:16 of the sum
                if (i == j) begin
                    lm[tri_pos(i, j)] = (c < 0) ? fix_t'(0) : int_sqrt(longint'(c) * 65536);
                end else begin
                    d = lm[tri_pos(j, j)];
                    if (d == 0) begin
                        lm[tri_pos(i, j)] = 32'h7fff_ffff;
                    end else begin
                        num = (longint'(c) * 65536) / longint'(d);   // Truncates toward zero
                        lm[tri_pos(i, j)] = num[31:0];
                    end
                end
            end
        end
        return lm;
    endfunction

    // A = B * B^T with B lower triangular
    task automatic make_spd(output tri_t am);
        fix_t        b [N][N];
        logic [31:0] r;
        longint      s;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                b[i][j] = '0;
                if (j < i) begin
                    take_bits(18, r);
                    b[i][j] = fix_t'(int'(r) - 131072);          // -2.0 up to 2.0
                end else if (j == i) begin
                    take_bits(18, r);
                    b[i][j] = fix_t'(65536 + int'(r) % 196609);  // 1.0 up to 4.0
                end
            end
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                s = 0;
                for (int k = 0; k <= j; k++) begin
                    s = s + longint'(b[i][k]) * longint'(b[j][k]);
                end
                am[tri_pos(i, j)] = fix_t'(s >>> 16);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_fix(input string name, input fix_t got, input fix_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            err_count++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Compare on every result pulse
    always @(negedge clk) begin
        if (l_valid === 1'b1) begin
            pulses++;
            for (int e = 0; e < TRI; e++) begin
                check_fix($sformatf("l[%0d]", e), l[e], expected_l[e]);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            abort_run();
        end
    end

    // ------------------------------------------------------------
    // Sequences
    // ------------------------------------------------------------
    task automatic strobe_matrix(input tri_t m);
        @(negedge clk);
        a       = m;
        a_valid = 1'b1;
        @(negedge clk);
        a_valid = 1'b0;
    endtask

    task automatic wait_result();
        while (pulses < exp_pulses) begin
            @(posedge clk);
        end
    endtask

    // l must hold and l_valid stay low
    task automatic idle_check(input int n);
        repeat (n) begin
            @(negedge clk);
            check_flag("l_valid", l_valid, 1'b0);
            for (int e = 0; e < TRI; e++) begin
                check_fix($sformatf("l[%0d] idle", e), l[e], expected_l[e]);
            end
        end
        check_count("l_valid pulses", pulses, exp_pulses);
    endtask

    task automatic run_matrix(input tri_t m, input tri_t exp);
        expected_l = exp;
        exp_pulses++;
        strobe_matrix(m);
        wait_result();
        idle_check(8);
    endtask

    initial begin
        tri_t m1;
        tri_t m2;
        tri_t ex;
        clk        = 1'b0;
        rst        = 1'b1;
        a          = '0;
        a_valid    = 1'b0;
        expected_l = '0;
        pulses     = 0;
        exp_pulses = 0;
        err_count  = 0;
        cycles     = 0;
        lfsr_q     = 32'hef34_b5eb;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Identity in, identity out
        m1 = '0;
        for (int i = 0; i < N; i++) begin
            m1[tri_pos(i, i)] = 32'h0001_0000;
        end
        run_matrix(m1, m1);

        // Perfect squares on the diagonal
        m1 = '0;
        ex = '0;
        for (int i = 0; i < N; i++) begin
            m1[tri_pos(i, i)] = fix_t'((i + 1) * (i + 1) * 65536);
            ex[tri_pos(i, i)] = fix_t'((i + 1) * 65536);
        end
        run_matrix(m1, ex);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            make_spd(m1);
            run_matrix(m1, cholesky_ref(m1));
        end

        // Strobes while busy are ignored
        make_spd(m1);
        make_spd(m2);
        expected_l = cholesky_ref(m1);
        exp_pulses++;
        strobe_matrix(m1);
        repeat (3) begin
            repeat (20) @(negedge clk);
            a       = m2;
            a_valid = 1'b1;
            @(negedge clk);
            a_valid = 1'b0;
        end
        wait_result();
        idle_check(20);

        // Reset in the middle of a run
        make_spd(m1);
        strobe_matrix(m1);
        repeat (100) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst        = 1'b0;
        expected_l = '0;
        idle_check(600);

        make_spd(m1);
        run_matrix(m1, cholesky_ref(m1));

        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
